// ==== common/rvPkg.sv ====
`default_nettype none

package rvPkg;

	localparam int xlen = 32;
	localparam int regCount = 32;
	localparam int regAddrW = 5;
	localparam int shamtW = 5;
	localparam int altBit = 30; // funct7 bit that selects sub and sra

	typedef enum logic [6:0] {
		opcOp = 7'b0110011,
		opcOpImm = 7'b0010011,
		opcLoad = 7'b0000011,
		opcStore = 7'b0100011,
		opcJal = 7'b1101111,
		opcJalr = 7'b1100111,
		opcBranch = 7'b1100011
	} opcode_t;

	// funct3 for OP and OP-IMM
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll = 3'b001;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Sltu = 3'b011;
	localparam logic [2:0] f3Xor = 3'b100;
	localparam logic [2:0] f3Srl = 3'b101;
	localparam logic [2:0] f3Or = 3'b110;
	localparam logic [2:0] f3And = 3'b111;

	// funct3 for branches
	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSll,
		aluSrl,
		aluSra,
		aluSlt,
		aluSltu,
		aluCmpEq,
		aluCmpNe
	} aluOp_t;

endpackage

`default_nettype wire

// ==== common/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

	import rvPkg::*;

	typedef enum logic [3:0] {
		fetch = 4'd1,
		decode = 4'd2,
		jalEx = 4'd3,
		brDecode = 4'd4,
		memImmEx = 4'd5, // lw and I-type
		storeEx = 4'd6,
		regEx = 4'd7,
		jalrEx = 4'd8,
		brEx = 4'd9,
		brDone = 4'd10,
		regWb = 4'd11, // R, I, jal and jalr write back
		loadMem = 4'd12,
		loadWb = 4'd13,
		storeMem = 4'd14
	} state_t;

	typedef enum logic {srcAPc, srcARs1} srcA_t;
	typedef enum logic [1:0] {srcBRs2, srcBImm, srcBFour} srcB_t;
	typedef enum logic {wbAluOut, wbMem} wbSel_t;
	typedef enum logic {pcSrcAlu, pcSrcAluOut} pcSrc_t;

	typedef struct packed {
		logic irWrite;
		logic pcWrite;
		logic pcWriteCond;
		logic aluOutWrite;
		logic regWrite;
		logic memWrite;
		srcA_t aluSrcA;
		srcB_t aluSrcB;
		wbSel_t wbSel;
		pcSrc_t pcSrc;
		aluOp_t aluOp;
	} ctrlWord_t;

endpackage

`default_nettype wire

// ==== control/multiCycleControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module multiCycleControl import rvPkg::*, ctrlPkg::*; (
	input wire CLK,
	input wire RSTn,
	input wire [xlen-1:0] instr,
	input wire aluZero,
	output ctrlWord_t ctrl,
	output logic [xlen-1:0] retired
);

	state_t state;
	state_t nextState;
	logic started; // Low for the first cycle after reset
	aluOp_t aluOp;
	opcode_t opcode;
	logic [2:0] funct3;
	logic alt;

	assign opcode = opcode_t'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign alt = instr[altBit];

	function automatic aluOp_t functOp(input logic [2:0] f3, input logic altSel,
			input logic regOp);
		case (f3)
			f3AddSub: return (altSel && regOp) ? aluSub : aluAdd; // addi has no sub
			f3Sll: return aluSll;
			f3Slt: return aluSlt;
			f3Sltu: return aluSltu;
			f3Xor: return aluXor;
			f3Srl: return altSel ? aluSra : aluSrl;
			f3Or: return aluOr;
			f3And: return aluAnd;
			default: return aluAdd;
		endcase
	endfunction

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			state <= fetch;
			started <= 1'b0;
			retired <= '0;
		end else begin
			started <= 1'b1;
			state <= nextState;
			if (state != fetch && nextState == fetch)
				retired <= retired + 1'b1; // Instruction completed
		end
	end

	always_comb begin
		nextState = fetch;
		if (started) begin
			case (state)
				fetch: begin
					case (opcode) // Fetch already sees the new word
						opcJal: nextState = jalEx;
						opcBranch: nextState = brDecode;
						default: nextState = decode;
					endcase
				end
				decode: begin
					case (opcode)
						opcOp: nextState = regEx;
						opcOpImm, opcLoad: nextState = memImmEx;
						opcStore: nextState = storeEx;
						opcJalr: nextState = jalrEx;
						default: nextState = fetch; // Unknown opcode
					endcase
				end
				jalEx, jalrEx, regEx: nextState = regWb;
				brDecode: nextState = brEx;
				brEx: nextState = brDone;
				memImmEx: nextState = (opcode == opcLoad) ? loadMem : regWb;
				storeEx: nextState = storeMem;
				loadMem: nextState = loadWb;
				default: nextState = fetch;
			endcase
		end
	end

	always_comb begin
		aluOp = aluAdd;
		case (state)
			regEx: aluOp = functOp(funct3, alt, 1'b1);
			memImmEx: begin
				if (opcode == opcOpImm)
					aluOp = functOp(funct3, alt, 1'b0);
			end
			brEx: begin
				case (funct3)
					f3Beq: aluOp = aluCmpEq;
					f3Bne: aluOp = aluCmpNe;
					default: aluOp = aluCmpEq;
				endcase
			end
			default: aluOp = aluAdd;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluOp;
		if (started) begin
			case (state)
				fetch: begin
					ctrl.irWrite = 1'b1;
					ctrl.aluOutWrite = 1'b1; // PC+4 kept in ALU-out
					ctrl.aluSrcA = srcAPc;
					ctrl.aluSrcB = srcBFour;
				end
				decode: begin
					ctrl.pcWrite = 1'b1;
					ctrl.pcSrc = pcSrcAluOut;
				end
				jalEx: begin
					ctrl.pcWrite = 1'b1;
					ctrl.aluSrcA = srcAPc;
					ctrl.aluSrcB = srcBImm;
					ctrl.pcSrc = pcSrcAlu;
				end
				brDecode: begin
					ctrl.pcWrite = 1'b1; // Fall-through PC
					ctrl.pcSrc = pcSrcAluOut;
					ctrl.aluOutWrite = 1'b1; // Branch target
					ctrl.aluSrcA = srcAPc;
					ctrl.aluSrcB = srcBImm;
				end
				memImmEx, storeEx: begin
					ctrl.aluOutWrite = 1'b1;
					ctrl.aluSrcA = srcARs1;
					ctrl.aluSrcB = srcBImm;
				end
				regEx: begin
					ctrl.aluOutWrite = 1'b1;
					ctrl.aluSrcA = srcARs1;
					ctrl.aluSrcB = srcBRs2;
				end
				jalrEx: begin
					ctrl.pcWrite = 1'b1;
					ctrl.aluSrcA = srcARs1;
					ctrl.aluSrcB = srcBImm;
					ctrl.pcSrc = pcSrcAlu;
				end
				brEx: begin
					ctrl.pcWriteCond = aluZero; // Taken branch only
					ctrl.aluSrcA = srcARs1;
					ctrl.aluSrcB = srcBRs2;
					ctrl.pcSrc = pcSrcAluOut;
				end
				regWb: begin
					ctrl.regWrite = 1'b1;
					ctrl.wbSel = wbAluOut;
				end
				loadWb: begin
					ctrl.regWrite = 1'b1;
					ctrl.wbSel = wbMem;
				end
				storeMem: ctrl.memWrite = 1'b1;
				default: ctrl.pcSrc = pcSrcAlu; // brDone, loadMem
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== datapath/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile import rvPkg::*; (
	input wire CLK,
	input wire [regAddrW-1:0] rs1,
	input wire [regAddrW-1:0] rs2,
	input wire [regAddrW-1:0] rd,
	input wire [xlen-1:0] wData,
	input wire we,
	output logic [xlen-1:0] rData1,
	output logic [xlen-1:0] rData2
);

	logic [xlen-1:0] regs [0:regCount-1];

	always_ff @(posedge CLK) begin
		if (we && rd != '0)
			regs[rd] <= wData;
	end

	assign rData1 = (rs1 == '0) ? '0 : regs[rs1]; // x0 reads zero
	assign rData2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== datapath/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit import rvPkg::*; (
	input wire [xlen-1:0] a,
	input wire [xlen-1:0] b,
	input wire aluOp_t op,
	output logic [xlen-1:0] y,
	output logic zero
);

	logic [shamtW-1:0] shamt;
	logic isCmp;

	assign shamt = b[shamtW-1:0];
	assign isCmp = (op == aluCmpEq) || (op == aluCmpNe);

	always_comb begin
		case (op)
			aluAdd: y = a + b;
			aluSub: y = a - b;
			aluAnd: y = a & b;
			aluOr: y = a | b;
			aluXor: y = a ^ b;
			aluSll: y = a << shamt;
			aluSrl: y = a >> shamt;
			aluSra: y = $signed(a) >>> shamt;
			aluSlt: y = xlen'($signed(a) < $signed(b));
			aluSltu: y = xlen'(a < b);
			aluCmpEq: y = xlen'(a == b);
			aluCmpNe: y = xlen'(a != b);
			default: y = '0;
		endcase
	end

	// Compares flag a taken branch on zero
	assign zero = isCmp ? y[0] : (y == '0);

endmodule

`default_nettype wire

// ==== datapath/immGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module immGen import rvPkg::*; (
	input wire [xlen-1:0] instr,
	output logic [xlen-1:0] imm
);

	logic sign;

	assign sign = instr[31];

	always_comb begin
		case (opcode_t'(instr[6:0]))
			opcStore: imm = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
			opcBranch: imm = {{(xlen-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			opcJal: imm = {{(xlen-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			default: imm = {{(xlen-12){sign}}, instr[31:20]}; // I format
		endcase
	end

endmodule

`default_nettype wire

// ==== datapath/cpuDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuDatapath import rvPkg::*, ctrlPkg::*; (
	input wire CLK,
	input wire RSTn,
	input wire ctrlWord_t ctrl,
	input wire [xlen-1:0] iData,
	input wire [xlen-1:0] dRdata,
	output logic [xlen-1:0] instr,
	output logic aluZero,
	output logic [xlen-1:0] iAddr,
	output logic [xlen-1:0] dAddr,
	output logic [xlen-1:0] dWdata
);

	logic [xlen-1:0] pc;
	logic [xlen-1:0] irReg;
	logic [xlen-1:0] aReg;
	logic [xlen-1:0] bReg;
	logic [xlen-1:0] aluOut;
	logic [xlen-1:0] mdr;
	logic [xlen-1:0] rData1;
	logic [xlen-1:0] rData2;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] aluA;
	logic [xlen-1:0] aluB;
	logic [xlen-1:0] aluY;
	logic [xlen-1:0] wbData;
	logic [xlen-1:0] pcNext;
	logic pcEn;

	regFile u_regFile (
		.CLK(CLK),
		.rs1(irReg[19:15]),
		.rs2(irReg[24:20]),
		.rd(irReg[11:7]),
		.wData(wbData),
		.we(ctrl.regWrite),
		.rData1(rData1),
		.rData2(rData2)
	);

	immGen u_immGen (
		.instr(irReg),
		.imm(imm)
	);

	aluUnit u_alu (
		.a(aluA),
		.b(aluB),
		.op(ctrl.aluOp),
		.y(aluY),
		.zero(aluZero)
	);

	always_comb begin
		aluA = (ctrl.aluSrcA == srcARs1) ? aReg : pc;
		case (ctrl.aluSrcB)
			srcBRs2: aluB = bReg;
			srcBImm: aluB = imm;
			default: aluB = xlen'(4);
		endcase
	end

	assign wbData = (ctrl.wbSel == wbMem) ? mdr : aluOut;
	assign pcNext = (ctrl.pcSrc == pcSrcAluOut) ? aluOut : aluY;
	assign pcEn = ctrl.pcWrite | ctrl.pcWriteCond;

	always_ff @(posedge CLK) begin
		if (RSTn)
			pc <= '0;
		else if (pcEn)
			pc <= {pcNext[xlen-1:1], 1'b0}; // jalr clears bit 0
	end

	always_ff @(posedge CLK) begin
		if (ctrl.irWrite)
			irReg <= iData;
		if (ctrl.aluOutWrite)
			aluOut <= aluY;
		aReg <= rData1;
		bReg <= rData2;
		mdr <= dRdata; // Holds load data in loadWb
	end

	// The controller sees the new word while it is being fetched
	assign instr = ctrl.irWrite ? iData : irReg;
	assign iAddr = pc;
	assign dAddr = aluOut;
	assign dWdata = bReg;

endmodule

`default_nettype wire

// ==== design/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTop import rvPkg::*, ctrlPkg::*; (
	input wire CLK,
	input wire RSTn,
	output logic [xlen-1:0] iAddr,
	input wire [xlen-1:0] iData,
	output logic [xlen-1:0] dAddr,
	output logic [xlen-1:0] dWdata,
	output logic dWe,
	input wire [xlen-1:0] dRdata,
	output logic [xlen-1:0] retired
);

	ctrlWord_t ctrl;
	logic [xlen-1:0] instr;
	logic aluZero;

	multiCycleControl u_control (
		.CLK(CLK),
		.RSTn(RSTn),
		.instr(instr),
		.aluZero(aluZero),
		.ctrl(ctrl),
		.retired(retired)
	);

	cpuDatapath u_datapath (
		.CLK(CLK),
		.RSTn(RSTn),
		.ctrl(ctrl),
		.iData(iData),
		.dRdata(dRdata),
		.instr(instr),
		.aluZero(aluZero),
		.iAddr(iAddr),
		.dAddr(dAddr),
		.dWdata(dWdata)
	);

	assign dWe = ctrl.memWrite;

endmodule

`default_nettype wire

// ==== tests/cpuChk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuChk import rvPkg::*, ctrlPkg::*; (
	input wire CLK,
	input wire RSTn,
	input wire ctrlWord_t ctrl,
	input wire state_t state
);

	int failures;
	logic anyWrite;

	initial failures = 0;

	assign anyWrite = ctrl.irWrite | ctrl.pcWrite | ctrl.pcWriteCond | ctrl.aluOutWrite
		| ctrl.regWrite | ctrl.memWrite;

	memWriteInStoreMem: assert property (@(posedge CLK) disable iff (RSTn)
		ctrl.memWrite |-> state == storeMem)
		else begin
			$error("data write strobe high outside storeMem");
			failures++;
		end

	irWriteInFetch: assert property (@(posedge CLK) disable iff (RSTn)
		ctrl.irWrite |-> state == fetch)
		else begin
			$error("instruction register written outside fetch");
			failures++;
		end

	// First reset cycle may still show the old state
	quietInReset: assert property (@(posedge CLK) RSTn && $past(RSTn) |-> !anyWrite)
		else begin
			$error("write control bit high while reset is held");
			failures++;
		end

endmodule

bind multiCycleControl cpuChk u_chk (
	.CLK(CLK),
	.RSTn(RSTn),
	.ctrl(ctrl),
	.state(state)
);

`default_nettype wire

// ==== tests/cpuMonitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuMonitor import rvPkg::*; (
	input wire CLK,
	input wire RSTn,
	input wire dWe,
	input wire [xlen-1:0] dAddr,
	input wire [xlen-1:0] dWdata,
	input wire [xlen-1:0] retired,
	output int pending,
	output int passCount,
	output int failCount
);

	typedef struct packed {
		logic [xlen-1:0] addr;
		logic [xlen-1:0] data;
		logic [xlen-1:0] count;
	} store_t;

	store_t expQ[$];
	store_t got;
	store_t want;
	string name;
	int mismatches;

	initial begin
		pending = 0;
		passCount = 0;
		failCount = 0;
		mismatches = 0;
		name = "";
	end

	task automatic beginTest(input string testName);
		name = testName;
		mismatches = 0;
		expQ.delete();
		pending = 0;
	endtask

	task automatic addStore(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
			input logic [xlen-1:0] count);
		store_t entry;
		entry.addr = addr;
		entry.data = data;
		entry.count = count;
		expQ.push_back(entry);
		pending = expQ.size();
	endtask

	task automatic finishTest(input bit late);
		if (late || mismatches != 0 || expQ.size() != 0) begin
			failCount++;
			$display("test %s failed", name);
		end else begin
			passCount++;
			$display("test %s passed", name);
		end
	endtask

	always @(posedge CLK) begin
		if (!RSTn && dWe) begin
			got.addr = dAddr;
			got.data = dWdata;
			got.count = retired; // Instructions completed so far
			if (expQ.size() == 0) begin
				$display("unexpected store in test %s to address %h", name, dAddr);
				mismatches++;
			end else begin
				want = expQ.pop_front();
				pending = expQ.size();
				if (got != want) begin
					$display("Fail %s expected addr/data/count %h/%h/%0d actual %h/%h/%0d",
						name, want.addr, want.data, want.count,
						got.addr, got.data, got.count);
					mismatches++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tests/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb import rvPkg::*; ();

	localparam int memWords = 64;
	localparam int idxW = 6;
	localparam int resetCycles = 10;
	localparam int drainCycles = 8;

	logic CLK;
	logic RSTn;
	logic [xlen-1:0] iAddr;
	logic [xlen-1:0] iData;
	logic [xlen-1:0] dAddr;
	logic [xlen-1:0] dWdata;
	logic dWe;
	logic [xlen-1:0] dRdata;
	logic [xlen-1:0] retired;
	logic [xlen-1:0] iMem [0:memWords-1];
	logic [xlen-1:0] dMem [0:memWords-1];
	logic [xlen-1:0] word;
	logic [xlen-1:0] addrVal;
	logic [xlen-1:0] dataVal;
	logic [8*128-1:0] skipLine;
	int pending;
	int passCount;
	int failCount;
	int fd;
	int code;
	int countVal;
	int instrCount;
	int testsRun;
	bit runBroken;
	bit inTest;
	string kind;
	string testName;

	cpuTop u_dut (
		.CLK(CLK),
		.RSTn(RSTn),
		.iAddr(iAddr),
		.iData(iData),
		.dAddr(dAddr),
		.dWdata(dWdata),
		.dWe(dWe),
		.dRdata(dRdata),
		.retired(retired)
	);

	cpuMonitor u_mon (
		.CLK(CLK),
		.RSTn(RSTn),
		.dWe(dWe),
		.dAddr(dAddr),
		.dWdata(dWdata),
		.retired(retired),
		.pending(pending),
		.passCount(passCount),
		.failCount(failCount)
	);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

	// Word-addressed memories with combinational reads
	assign iData = iMem[iAddr[idxW+1:2]];
	assign dRdata = dMem[dAddr[idxW+1:2]];

	always @(posedge CLK) begin
		if (dWe)
			dMem[dAddr[idxW+1:2]] <= dWdata;
	end

	task automatic clearMemories();
		for (int i = 0; i < memWords; i++) begin
			iMem[i] = '0;
			dMem[i] = '0;
		end
	endtask

	task automatic runTest();
		int limit;
		int cycles;
		limit = 6 * instrCount + 20;
		cycles = 0;
		repeat (resetCycles) @(negedge CLK);
		RSTn = 1'b0;
		while (pending != 0 && cycles < limit) begin
			@(negedge CLK);
			cycles++;
		end
		if (pending != 0) begin
			$display("timeout in test %s after %0d cycles", testName, limit);
			runBroken = 1'b1;
		end else
			repeat (drainCycles) @(negedge CLK); // Catch stray stores
		u_mon.finishTest(runBroken);
	endtask

	initial begin
		RSTn = 1'b1;
		runBroken = 1'b0;
		inTest = 1'b0;
		testsRun = 0;
		instrCount = 0;
		clearMemories();
		fd = $fopen("tests/cpuTests.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/cpuTests.txt");
			runBroken = 1'b1;
		end
		while (!runBroken && $fscanf(fd, "%s", kind) == 1) begin
			case (kind)
				"T": begin
					code = $fscanf(fd, "%s", testName);
					@(negedge CLK);
					RSTn = 1'b1;
					clearMemories();
					instrCount = 0;
					inTest = 1'b1;
					u_mon.beginTest(testName);
				end
				"I": begin
					code = $fscanf(fd, "%h", word);
					if (instrCount >= memWords) begin
						$display("program of test %s does not fit the memory", testName);
						runBroken = 1'b1;
					end else begin
						iMem[instrCount] = word;
						instrCount++;
					end
				end
				"S": begin
					code = $fscanf(fd, "%h %h %d", addrVal, dataVal, countVal);
					u_mon.addStore(addrVal, dataVal, countVal);
				end
				"E": begin
					runTest();
					inTest = 1'b0;
					testsRun++;
				end
				default: begin
					if (kind.substr(0, 0) == "#")
						code = $fgets(skipLine, fd);
					else begin
						$display("unknown record %s in test file", kind);
						runBroken = 1'b1;
					end
				end
			endcase
		end
		if (inTest && !runBroken) begin
			$display("test file ends inside test %s", testName);
			runBroken = 1'b1;
		end
		if (fd != 0)
			$fclose(fd);
		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (!runBroken && testsRun > 0 && failCount == 0 && u_dut.u_control.u_chk.failures == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
common/rvPkg.sv
common/ctrlPkg.sv
control/multiCycleControl.sv
datapath/regFile.sv
datapath/aluUnit.sv
datapath/immGen.sv
datapath/cpuDatapath.sv
design/cpuTop.sv
tests/cpuChk.sv
tests/cpuMonitor.sv
tests/cpuTb.sv

// ==== tests/cpuTests.txt ====
# T name | I instruction word in hex, in order from address 0 | E ends the test
# S store address (hex) data (hex) retired count (decimal)
T alu
I 06400093
I ff900113
I 402081b3
I 00112233
I 40115293
I 0f00c313
I 004093b3
I 00508013
I 00302023
I 00402223
I 00502423
I 00602623
I 00702a23
I 00002823
I 0000006f
S 00000000 0000006b 8
S 00000004 00000001 9
S 00000008 fffffffc 10
S 0000000c 00000094 11
S 00000014 000000c8 12
S 00000010 00000000 13
E
T load
I 5a500093
I 04102023
I 04002103
I 04202223
I 0000006f
S 00000040 000005a5 1
S 00000044 000005a5 3
E
T branch
I 00500093
I 00500113
I 00900193
I 00208463
I 00302023
I 00308463
I 00102223
I 00309463
I 00302423
I 00209463
I 00302623
I 0000006f
S 00000004 00000005 5
S 0000000c 00000009 8
E
T jump
I 008000ef
I 00002023
I 00102223
I 01800293
I 00028367
I 00002423
I 00602623
I 0000006f
S 00000004 00000004 1
S 0000000c 00000014 4
E
